// ==== logic/n163_pkg.sv ====
// shared bus structs, register select codes and address constants, imported by every mapper file
`default_nettype none

package n163_pkg;

	localparam logic [5:0] prg_last_page = 6'h3f; // fixed page at E000
	localparam logic [7:0] ciram_floor = 8'he0;
	localparam logic [15:0] wram_base = 16'h6000;
	localparam logic [15:0] wram_end = 16'h7fff;
	localparam logic [3:0] irq_window = 4'b0101; // 5000-5FFF
	localparam int cnt_width = 16;

	// one strobed CPU cycle
	typedef struct packed {
		logic ce;
		logic write;
		logic [15:0] addr;
		logic [7:0] data;
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] chr_addr;
	} ppu_bus_t;

	// 18 targets, so five bits
	typedef enum logic [4:0] {
		none,
		chr0, chr1, chr2, chr3, chr4, chr5, chr6, chr7,
		nt0, nt1, nt2, nt3,
		prg0, prg1_chren, prg2,
		irq_lo, irq_hi
	} reg_sel_t;

	typedef struct packed {
		reg_sel_t sel;
		logic [7:0] data;
	} reg_write_t;

	typedef logic [5:0] prg_page_t;
	typedef logic [7:0] chr_page_t;

	typedef struct packed {
		chr_page_t [11:0] chr; // 0-7 pattern, 8-11 nametable
		prg_page_t [2:0] prg;  // 8000, A000, C000
		logic [1:0] chr_en;
	} bank_set_t;

endpackage

`default_nettype wire

// ==== logic/n163_reg_decode.sv ====
// register write decoder, turns each strobed CPU cycle into a write command and an IRQ acknowledge
`default_nettype none

module n163_reg_decode (
	input logic clk20,
	input logic reset,
	input n163_pkg::cpu_bus_t cpu,
	output n163_pkg::reg_write_t wr_cmd,
	output logic irq_ack
);
	import n163_pkg::*;

	reg_sel_t sel;

	always_comb begin
		sel = none;
		if (cpu.ce && cpu.write) begin
			case (cpu.addr[15:11])
				5'b01010: sel = irq_lo; // 5000
				5'b01011: sel = irq_hi; // 5800
				5'b10000: sel = chr0;
				5'b10001: sel = chr1;
				5'b10010: sel = chr2;
				5'b10011: sel = chr3;
				5'b10100: sel = chr4;
				5'b10101: sel = chr5;
				5'b10110: sel = chr6;
				5'b10111: sel = chr7;
				5'b11000: sel = nt0; // C000
				5'b11001: sel = nt1;
				5'b11010: sel = nt2;
				5'b11011: sel = nt3;
				5'b11100: sel = prg0; // E000
				5'b11101: sel = prg1_chren;
				5'b11110: sel = prg2;
				default: sel = none; // F800 is sound, not kept
			endcase
		end
	end

	assign wr_cmd.sel = sel;
	assign wr_cmd.data = cpu.data;
	// any access to the counter window acks, reads too
	assign irq_ack = cpu.ce && (cpu.addr[15:12] == irq_window);

	// a strobed cycle carries a known direction and address
	a_strobe_known: assert property (@(posedge clk20) disable iff (reset)
		cpu.ce |-> !$isunknown({cpu.write, cpu.addr}));

endmodule

`default_nettype wire

// ==== logic/n163_bank_regs.sv ====
// CHR, nametable and PRG bank registers plus the CHR-RAM enable bits, written by decoded commands
`default_nettype none

module n163_bank_regs (
	input logic clk20,
	input logic reset,
	input n163_pkg::reg_write_t wr_cmd,
	output n163_pkg::bank_set_t banks
);
	import n163_pkg::*;

	logic [3:0] chr_idx;

	// chr0..nt3 are contiguous in the enum
	assign chr_idx = 4'(wr_cmd.sel - chr0);

	always_ff @(posedge clk20) begin
		if (reset) begin
			banks <= '0;
		end else begin
			case (wr_cmd.sel)
				chr0, chr1, chr2, chr3, chr4, chr5, chr6, chr7,
				nt0, nt1, nt2, nt3: begin
					banks.chr[chr_idx] <= wr_cmd.data;
				end
				prg0: begin
					banks.prg[0] <= wr_cmd.data[5:0]; // mirroring bits dropped
				end
				prg1_chren: begin
					banks.chr_en <= wr_cmd.data[7:6];
					banks.prg[1] <= wr_cmd.data[5:0];
				end
				prg2: begin
					banks.prg[2] <= wr_cmd.data[5:0];
				end
				default: begin
					// counter writes and idle cycles leave the banks alone
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/n163_irq_counter.sv ====
// 15-bit up-counting interrupt counter with byte loads and a sticky timeout flag driving irq
`default_nettype none

module n163_irq_counter (
	input logic clk20,
	input logic reset,
	input logic ce,
	input n163_pkg::reg_write_t wr_cmd,
	input logic irq_ack,
	output logic [n163_pkg::cnt_width-1:0] count,
	output logic irq
);
	import n163_pkg::*;

	logic [cnt_width-1:0] count_next;
	logic step;
	logic timeout;

	// enabled by bit 15, stops once the low bits saturate
	assign step = count[cnt_width-1] && !(&count[cnt_width-2:0]);
	assign count_next = count + cnt_width'(1);

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
			timeout <= 1'b0;
		end else if (ce) begin
			if (irq_ack)
				timeout <= 1'b0;
			else if (&count)
				timeout <= 1'b1;

			if (wr_cmd.sel == irq_lo)
				count[7:0] <= wr_cmd.data;
			else if (step)
				count[7:0] <= count_next[7:0];

			if (wr_cmd.sel == irq_hi)
				count[15:8] <= wr_cmd.data;
			else if (step)
				count[15:8] <= count_next[15:8]; // carry from low byte
		end
	end

	assign irq = timeout;

	// once saturated only a load can move it
	a_hold_at_max: assert property (@(posedge clk20) disable iff (reset)
		((&count) && !(ce && (wr_cmd.sel inside {irq_lo, irq_hi}))) |=> (&count));

endmodule

`default_nettype wire

// ==== logic/n163_prg_map.sv ====
// CPU side address map, gives the program page, work-RAM select, access allow and counter readback
`default_nettype none

module n163_prg_map (
	input n163_pkg::cpu_bus_t cpu,
	input n163_pkg::prg_page_t [2:0] prg,
	input logic [n163_pkg::cnt_width-1:0] count,
	output n163_pkg::prg_page_t prg_page,
	output logic wram_sel,
	output logic prg_allow,
	output logic prg_oe,
	output logic [7:0] prg_dout
);
	import n163_pkg::*;

	prg_page_t page_sel;
	logic cnt_rd;

	always_comb begin
		case (cpu.addr[14:13])
			2'd0: page_sel = prg[0];
			2'd1: page_sel = prg[1];
			2'd2: page_sel = prg[2];
			default: page_sel = prg_last_page; // E000 never moves
		endcase
	end

	assign prg_page = cpu.addr[15] ? page_sel : '0;
	assign wram_sel = (cpu.addr >= wram_base) && (cpu.addr <= wram_end);
	assign prg_allow = wram_sel || (cpu.addr[15] && !cpu.write); // ROM is read only

	assign cnt_rd = (cpu.addr[15:12] == irq_window);
	assign prg_dout = !cnt_rd ? cpu.data :
		cpu.addr[11] ? count[15:8] : count[7:0];
	assign prg_oe = !cpu.write && (wram_sel || cpu.addr[15] || cnt_rd);

endmodule

`default_nettype wire

// ==== logic/n163_chr_map.sv ====
// PPU side address map, picks the 1 KiB pattern page and decides when nametable RAM answers
`default_nettype none

module n163_chr_map (
	input n163_pkg::ppu_bus_t ppu,
	input n163_pkg::bank_set_t banks,
	output n163_pkg::chr_page_t chr_page,
	output logic ciram_ce,
	output logic ciram_a10
);
	import n163_pkg::*;

	logic [3:0] region;
	logic [3:0] bank_idx;
	chr_page_t bank;
	logic bank_ram;
	logic half_off;

	assign region = ppu.chr_addr[13:10];
	// 2000-3FFF folds onto the four nametable banks
	assign bank_idx = region[3] ? {2'b10, region[1:0]} : region;
	assign bank = banks.chr[bank_idx];

	// E0-FF means internal nametable RAM
	assign bank_ram = (bank >= ciram_floor);
	assign half_off = ppu.chr_addr[12] ? banks.chr_en[1] : banks.chr_en[0];

	always_comb begin
		if (ppu.chr_addr[13])
			ciram_ce = bank_ram;
		else
			ciram_ce = bank_ram && !half_off; // chr_en set keeps ROM there
	end

	assign chr_page = bank;
	assign ciram_a10 = bank[0];

endmodule

`default_nettype wire

// ==== logic/n163_mapper.sv ====
// Namco 163 mapper top, connects the write decoder, bank and counter registers and both address maps
`default_nettype none

module n163_mapper (
	input logic clk20,
	input logic reset,
	input n163_pkg::cpu_bus_t cpu,
	input n163_pkg::ppu_bus_t ppu,
	output n163_pkg::prg_page_t prg_page,
	output logic wram_sel,
	output logic prg_allow,
	output logic prg_oe,
	output logic [7:0] prg_dout,
	output n163_pkg::chr_page_t chr_page,
	output logic ciram_ce,
	output logic ciram_a10,
	output logic irq
);
	import n163_pkg::*;

	reg_write_t wr_cmd;
	logic irq_ack;
	bank_set_t banks;
	logic [cnt_width-1:0] count;

	n163_reg_decode u_decode (
		.clk20   (clk20),
		.reset   (reset),
		.cpu     (cpu),
		.wr_cmd  (wr_cmd),
		.irq_ack (irq_ack)
	);

	n163_bank_regs u_banks (
		.clk20  (clk20),
		.reset  (reset),
		.wr_cmd (wr_cmd),
		.banks  (banks)
	);

	n163_irq_counter u_irq (
		.clk20   (clk20),
		.reset   (reset),
		.ce      (cpu.ce),
		.wr_cmd  (wr_cmd),
		.irq_ack (irq_ack),
		.count   (count),
		.irq     (irq)
	);

	n163_prg_map u_prg (
		.cpu       (cpu),
		.prg       (banks.prg),
		.count     (count),
		.prg_page  (prg_page),
		.wram_sel  (wram_sel),
		.prg_allow (prg_allow),
		.prg_oe    (prg_oe),
		.prg_dout  (prg_dout)
	);

	n163_chr_map u_chr (
		.ppu       (ppu),
		.banks     (banks),
		.chr_page  (chr_page),
		.ciram_ce  (ciram_ce),
		.ciram_a10 (ciram_a10)
	);

	// an ack from the decoder always wins over a new timeout
	a_ack_clears_irq: assert property (@(posedge clk20) disable iff (reset)
		irq_ack |=> !irq);

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
// clock and reset source for the mapper testbench, 10 ns period with reset held for 3 cycles
`default_nettype none

module tb_clock (
	output logic clk20,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk20 = 1'b0;
		reset = 1'b1;
		repeat (3) @(posedge clk20);
		@(negedge clk20);
		reset = 1'b0; // released between edges
	end

	always #5 clk20 = ~clk20;

endmodule

`default_nettype wire

// ==== verif/tb_n163.sv ====
// mapper testbench top, replays the trace file through the DUT and checks every output it names
`default_nettype none

module tb_n163;
	timeunit 1ns;
	timeprecision 100ps;
	import n163_pkg::*;

	logic clk20;
	logic reset;
	cpu_bus_t cpu;
	ppu_bus_t ppu;
	prg_page_t prg_page;
	logic wram_sel;
	logic prg_allow;
	logic prg_oe;
	logic [7:0] prg_dout;
	chr_page_t chr_page;
	logic ciram_ce;
	logic ciram_a10;
	logic irq;
	int errors;
	int checks;
	int settle;

	tb_clock u_clock (
		.clk20 (clk20),
		.reset (reset)
	);

	n163_mapper dut (
		.clk20     (clk20),
		.reset     (reset),
		.cpu       (cpu),
		.ppu       (ppu),
		.prg_page  (prg_page),
		.wram_sel  (wram_sel),
		.prg_allow (prg_allow),
		.prg_oe    (prg_oe),
		.prg_dout  (prg_dout),
		.chr_page  (chr_page),
		.ciram_ce  (ciram_ce),
		.ciram_a10 (ciram_a10),
		.irq       (irq)
	);

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp)
		else begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// called on a falling edge, ce stays up until the next one
	task automatic start_cycle(input logic wr, input logic [15:0] addr, input logic [7:0] data);
		cpu = '{ce: 1'b1, write: wr, addr: addr, data: data};
		#1; // outputs settle well before the sampling edge
	endtask

	task automatic end_cycle();
		@(negedge clk20);
		cpu.ce = 1'b0;
		cpu.write = 1'b0;
	endtask

	task automatic replay_trace();
		int fd;
		int got;
		int lnum;
		string line;
		string tag;
		byte op;
		logic [15:0] a0;
		logic [15:0] a1;
		logic [15:0] a2;
		logic [15:0] a3;
		fd = $fopen("verif/n163_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the trace file verif/n163_trace.txt");
		end else begin
			lnum = 0;
			while (!$feof(fd) && lnum < 1000) begin
				got = $fgets(line, fd);
				lnum++;
				if (got == 0 || line.len() < 2 || line.getc(0) == "#")
					continue;
				op = line.getc(0);
				a0 = '0;
				a1 = '0;
				a2 = '0;
				a3 = '0;
				got = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a0, a1, a2, a3);
				tag = $sformatf("line %0d", lnum);
				case (op)
					"W": begin
						start_cycle(1'b1, a0, a1[7:0]);
						end_cycle();
					end
					"R": begin
						start_cycle(1'b0, a0, 8'h00);
						check_val({tag, " prg_dout"}, a1, 16'(prg_dout));
						check_val({tag, " prg_oe"}, a2, 16'(prg_oe));
						end_cycle();
					end
					"P": begin
						start_cycle(1'b0, a0, 8'h00);
						check_val({tag, " prg_page"}, a1, 16'(prg_page));
						check_val({tag, " wram_sel"}, a2, 16'(wram_sel));
						check_val({tag, " prg_allow"}, a3, 16'(prg_allow));
						end_cycle();
					end
					"C": begin
						ppu.chr_addr = a0[13:0]; // PPU side needs no strobe
						#1;
						check_val({tag, " chr_page"}, a1, 16'(chr_page));
						check_val({tag, " ciram_ce"}, a2, 16'(ciram_ce));
						check_val({tag, " ciram_a10"}, a3, 16'(ciram_a10));
						@(negedge clk20);
					end
					"T": begin
						repeat (a0) begin
							start_cycle(1'b0, 16'h8000 | 16'($urandom()), 8'h00); // ROM reads
							end_cycle();
						end
					end
					"I": begin
						#1;
						check_val({tag, " irq"}, a0, 16'(irq));
						@(negedge clk20);
					end
					default: begin
						errors++;
						$display("%s holds an unknown command", tag);
					end
				endcase
			end
			if (!$feof(fd)) begin
				errors++;
				$display("trace replay stopped after %0d lines without reaching the end", lnum);
			end
			$fclose(fd);
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		cpu = '0;
		ppu = '0;
		void'($urandom(92382));
		settle = 0;
		while (reset !== 1'b0 && settle < 20) begin
			@(negedge clk20);
			settle++;
		end
		if (reset !== 1'b0) begin
			$display("reset was never released");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			@(negedge clk20);
			replay_trace();
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verif/n163_trace.txt ====
# W addr data | R addr data oe | P addr page wram_sel prg_allow | I irq
# C ppu_addr chr_page ciram_ce ciram_a10 | T idle_strobes, all values hex
I 0
P 8000 00 0 1
P a000 00 0 1
P c000 00 0 1
P e000 3f 0 1
W e000 05
W e800 6a
W f000 3c
P 8000 05 0 1
P a000 2a 0 1
P c000 3c 0 1
P e000 3f 0 1
P 6000 00 1 1
W 8000 10
W 8800 e1
W 9000 22
W 9800 f3
W a000 e4
W a800 45
W b000 ff
W b800 df
W c000 e0
W c800 e1
W d000 7e
W d800 fe
C 0000 10 0 0
C 0400 e1 0 1
C 0800 22 0 0
C 0c00 f3 0 1
C 1000 e4 1 0
C 1400 45 0 1
C 1800 ff 1 1
C 1c00 df 0 1
C 2000 e0 1 0
C 2400 e1 1 1
C 2800 7e 0 0
C 2c00 fe 1 0
C 3000 e0 1 0
C 3400 e1 1 1
C 3800 7e 0 0
C 3c00 fe 1 0
W e800 aa
C 0400 e1 1 1
C 1000 e4 0 0
C 2400 e1 1 1
W 5000 34
W 5800 12
R 5000 34 1
R 5800 12 1
W 5800 ff
W 5000 fd
T 2
R 5000 ff 1
I 0
T 1
I 1
R 5800 ff 1
I 0

// ==== files.f ====
logic/n163_pkg.sv
logic/n163_reg_decode.sv
logic/n163_bank_regs.sv
logic/n163_irq_counter.sv
logic/n163_prg_map.sv
logic/n163_chr_map.sv
logic/n163_mapper.sv
verif/tb_clock.sv
verif/tb_n163.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = tb_n163
FILELIST = files.f
BUILD = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
